// File: src/ghash_pkg.sv
package ghash_pkg;

    // width of one GHASH block
    localparam int NB_BLOCK = 128;

    // blocks carried per input beat
    // the accumulate formula in the core holds for two lanes only
    localparam int N_LANES = 2;

    // full beat width, block 0 in the low bits
    localparam int NB_DATA = NB_BLOCK * N_LANES;

    // blocks-absorbed counter width
    localparam int NB_COUNT = 16;

    // reduction constant for 1 + x + x^2 + x^7 + x^128
    // reflected order, so 0xe1 sits in the top byte
    localparam logic [NB_BLOCK-1:0] R_POLY = {8'he1, 120'd0};

    // control states
    typedef enum logic [1:0] {
        // after reset, no key yet
        ST_NO_KEY   = 2'd0,
        // H registered, H^2 being formed
        ST_KEY_CALC = 2'd1,
        // key ready, no message open
        ST_IDLE     = 2'd2,
        // message open
        ST_MSG      = 2'd3
    } ctrl_state_t;

endpackage

// File: src/gf128_mult.sv
`timescale 1ns/1ps

module gf128_mult (
    input  logic [ghash_pkg::NB_BLOCK-1:0] i_a,
    input  logic [ghash_pkg::NB_BLOCK-1:0] i_b,
    output logic [ghash_pkg::NB_BLOCK-1:0] o_z
);

    // shift-and-add over GF(2^128), GCM bit order
    // bit 127 of a vector is coefficient x^0, bit 0 is x^127
    // so a right shift multiplies by x

    // running partial product, one entry per processed bit of i_a
    logic [ghash_pkg::NB_BLOCK-1:0] z_chain [0:ghash_pkg::NB_BLOCK];

    // i_b times x^k, already reduced
    logic [ghash_pkg::NB_BLOCK-1:0] v_chain [0:ghash_pkg::NB_BLOCK-1];

    assign z_chain[0] = '0;
    assign v_chain[0] = i_b;

    for (genvar gi = 0; gi < ghash_pkg::NB_BLOCK; gi++) begin : g_step

        // coefficient x^gi of i_a lives at bit 127-gi
        // add the matching power of i_b when it is set
        assign z_chain[gi+1] = i_a[ghash_pkg::NB_BLOCK-1-gi]
                             ? (z_chain[gi] ^ v_chain[gi])
                             : z_chain[gi];

        // last step needs no further power of i_b
        if (gi < ghash_pkg::NB_BLOCK - 1) begin : g_shift
            // multiply by x
            // bit 0 leaving means an x^128 term, fold it back with R
            assign v_chain[gi+1] = (v_chain[gi] >> 1)
                                 ^ ({ghash_pkg::NB_BLOCK{v_chain[gi][0]}}
                                    & ghash_pkg::R_POLY);
        end

    end

    // fully reduced product
    assign o_z = z_chain[ghash_pkg::NB_BLOCK];

endmodule

// File: src/ghash_key_powers.sv
`timescale 1ns/1ps

module ghash_key_powers (
    input  logic                           i_clock,
    input  logic                           i_reset,
    input  logic                           i_key_load,
    input  logic [ghash_pkg::NB_BLOCK-1:0] i_key,
    output logic [ghash_pkg::NB_BLOCK-1:0] o_h,
    output logic [ghash_pkg::NB_BLOCK-1:0] o_h2
);

    // hash subkey H
    logic [ghash_pkg::NB_BLOCK-1:0] h_q;

    // second power H^2
    logic [ghash_pkg::NB_BLOCK-1:0] h2_q;

    // squaring result, combinational from h_q
    logic [ghash_pkg::NB_BLOCK-1:0] h_sq;

    // key was loaded last cycle, H^2 due now
    logic load_q;

    // H squared, one multiplier stage
    gf128_mult u_square (
        .i_a (h_q),
        .i_b (h_q),
        .o_z (h_sq)
    );

    // delayed load strobe
    // lines up with the ST_KEY_CALC cycle of the controller
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            load_q <= 1'b0;
        end else begin
            load_q <= i_key_load;
        end
    end

    // capture H on the load strobe
    always_ff @(posedge i_clock) begin
        if (i_key_load) begin
            h_q <= i_key;
        end
    end

    // H^2 follows one cycle later from the stored H
    // both powers then hold until the next load
    always_ff @(posedge i_clock) begin
        if (load_q) begin
            h2_q <= h_sq;
        end
    end

    assign o_h  = h_q;
    assign o_h2 = h2_q;

endmodule

// File: src/ghash_core.sv
`timescale 1ns/1ps

module ghash_core (
    input  logic                           i_clock,
    input  logic                           i_reset,
    input  logic                           i_beat_en,
    input  logic                           i_beat_restart,
    input  logic                           i_beat_last,
    input  logic                           i_beat_skip,
    input  logic [ghash_pkg::NB_DATA-1:0]  i_data,
    input  logic [ghash_pkg::NB_BLOCK-1:0] i_h,
    input  logic [ghash_pkg::NB_BLOCK-1:0] i_h2,
    output logic [ghash_pkg::NB_BLOCK-1:0] o_hash,
    output logic                           o_hash_valid
);

    // running Y of the open message
    logic [ghash_pkg::NB_BLOCK-1:0] acc_q;

    // Y seen by this beat, zero on sop
    logic [ghash_pkg::NB_BLOCK-1:0] y_in;

    // lane 0 operands and product
    logic [ghash_pkg::NB_BLOCK-1:0] lane0_x;
    logic [ghash_pkg::NB_BLOCK-1:0] lane0_key;
    logic [ghash_pkg::NB_BLOCK-1:0] lane0_prod;

    // lane 1 product, raw and masked
    logic [ghash_pkg::NB_BLOCK-1:0] lane1_prod;
    logic [ghash_pkg::NB_BLOCK-1:0] lane1_keep;

    // next Y
    logic [ghash_pkg::NB_BLOCK-1:0] y_new;

    // restart beat begins from Y = 0
    assign y_in = i_beat_restart ? '0 : acc_q;

    // lane 0 carries the history, block 0 folded in
    assign lane0_x = y_in ^ i_data[0 +: ghash_pkg::NB_BLOCK];

    // two blocks need H^2 on lane 0
    // single block beat shortens to (Y ^ X0) * H
    assign lane0_key = i_beat_skip ? i_h : i_h2;

    gf128_mult u_lane0 (
        .i_a (lane0_x),
        .i_b (lane0_key),
        .o_z (lane0_prod)
    );

    // lane 1, block 1 times H
    gf128_mult u_lane1 (
        .i_a (i_data[ghash_pkg::NB_BLOCK +: ghash_pkg::NB_BLOCK]),
        .i_b (i_h),
        .o_z (lane1_prod)
    );

    // block 1 absent on a skip beat
    assign lane1_keep = lane1_prod & {ghash_pkg::NB_BLOCK{~i_beat_skip}};

    // (Y ^ X0) * H^2 ^ X1 * H
    assign y_new = lane0_prod ^ lane1_keep;

    // accumulator step per accepted beat
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            acc_q <= '0;
        end else if (i_beat_en) begin
            acc_q <= y_new;
        end
    end

    // final hash, held until the next message closes
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_hash <= '0;
        end else if (i_beat_en && i_beat_last) begin
            o_hash <= y_new;
        end
    end

    // one-cycle result strobe
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_hash_valid <= 1'b0;
        end else begin
            o_hash_valid <= i_beat_en & i_beat_last;
        end
    end

endmodule

// File: src/ghash_ctrl.sv
`timescale 1ns/1ps

module ghash_ctrl (
    input  logic i_clock,
    input  logic i_reset,
    input  logic i_key_valid,
    input  logic i_valid,
    input  logic i_sop,
    input  logic i_eop,
    input  logic i_skip,
    output logic o_ready,
    output logic o_key_load,
    output logic o_beat_en,
    output logic o_beat_restart,
    output logic o_beat_last,
    output logic o_beat_skip,
    output logic o_proto_error
);

    ghash_pkg::ctrl_state_t state_q;
    ghash_pkg::ctrl_state_t state_d;

    // handshake on the beat stream
    logic accept;

    // beat accepted with no message open and no sop
    logic orphan;

    // beats only while a key is ready
    assign o_ready = (state_q == ghash_pkg::ST_IDLE) || (state_q == ghash_pkg::ST_MSG);
    assign accept  = i_valid & o_ready;

    // key only between messages
    // a beat in the same idle cycle wins, the key is then ignored
    assign o_key_load = i_key_valid
                      & ((state_q == ghash_pkg::ST_NO_KEY)
                         | ((state_q == ghash_pkg::ST_IDLE) & ~i_valid));

    assign orphan = accept & (state_q == ghash_pkg::ST_IDLE) & ~i_sop;

    // beat goes into the datapath unless it is an orphan
    assign o_beat_en      = accept & ~orphan;
    assign o_beat_restart = o_beat_en & i_sop;
    assign o_beat_last    = o_beat_en & i_eop;
    // skip only counts on the closing beat
    assign o_beat_skip    = o_beat_last & i_skip;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ghash_pkg::ST_NO_KEY: begin
                if (o_key_load) begin
                    state_d = ghash_pkg::ST_KEY_CALC;
                end
            end
            // single cycle for H^2
            ghash_pkg::ST_KEY_CALC: begin
                state_d = ghash_pkg::ST_IDLE;
            end
            ghash_pkg::ST_IDLE: begin
                if (o_key_load) begin
                    state_d = ghash_pkg::ST_KEY_CALC;
                end else if (o_beat_en && !i_eop) begin
                    state_d = ghash_pkg::ST_MSG;
                end
            end
            // sop mid-message just restarts, state unchanged
            ghash_pkg::ST_MSG: begin
                if (o_beat_last) begin
                    state_d = ghash_pkg::ST_IDLE;
                end
            end
            default: begin
                state_d = ghash_pkg::ST_NO_KEY;
            end
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state_q       <= ghash_pkg::ST_NO_KEY;
            o_proto_error <= 1'b0;
        end else begin
            state_q <= state_d;
            // sticky until reset
            if (orphan) begin
                o_proto_error <= 1'b1;
            end
        end
    end

endmodule

// File: src/ghash_block_counter.sv
`timescale 1ns/1ps

module ghash_block_counter (
    input  logic                           i_clock,
    input  logic                           i_reset,
    input  logic                           i_beat_en,
    input  logic                           i_beat_restart,
    input  logic                           i_beat_skip,
    output logic [ghash_pkg::NB_COUNT-1:0] o_block_count
);

    // count before this beat, zero on sop
    logic [ghash_pkg::NB_COUNT-1:0] base;
    // blocks in this beat
    logic [1:0]                     step;
    // one extra bit for the carry out
    logic [ghash_pkg::NB_COUNT:0]   sum_wide;

    assign base     = i_beat_restart ? '0 : o_block_count;
    assign step     = i_beat_skip ? 2'd1 : 2'd2;
    assign sum_wide = {1'b0, base} + {{(ghash_pkg::NB_COUNT-1){1'b0}}, step};

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_block_count <= '0;
        end else if (i_beat_en) begin
            // saturate at all ones on overflow
            o_block_count <= sum_wide[ghash_pkg::NB_COUNT]
                           ? '1
                           : sum_wide[ghash_pkg::NB_COUNT-1:0];
        end
    end

endmodule

// File: src/ghash_top.sv
`timescale 1ns/1ps

module ghash_top (
    input  logic                           i_clock,
    input  logic                           i_reset,
    input  logic                           i_key_valid,
    input  logic [ghash_pkg::NB_BLOCK-1:0] i_key,
    input  logic                           i_valid,
    input  logic [ghash_pkg::NB_DATA-1:0]  i_data,
    input  logic                           i_sop,
    input  logic                           i_eop,
    input  logic                           i_skip,
    output logic                           o_ready,
    output logic [ghash_pkg::NB_BLOCK-1:0] o_hash,
    output logic                           o_hash_valid,
    output logic [ghash_pkg::NB_COUNT-1:0] o_block_count,
    output logic                           o_proto_error
);

    // controller strobes
    logic key_load;
    logic beat_en;
    logic beat_restart;
    logic beat_last;
    logic beat_skip;

    // key powers into the core
    logic [ghash_pkg::NB_BLOCK-1:0] h;
    logic [ghash_pkg::NB_BLOCK-1:0] h2;

    ghash_ctrl u_ctrl (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_key_valid    (i_key_valid),
        .i_valid        (i_valid),
        .i_sop          (i_sop),
        .i_eop          (i_eop),
        .i_skip         (i_skip),
        .o_ready        (o_ready),
        .o_key_load     (key_load),
        .o_beat_en      (beat_en),
        .o_beat_restart (beat_restart),
        .o_beat_last    (beat_last),
        .o_beat_skip    (beat_skip),
        .o_proto_error  (o_proto_error)
    );

    ghash_block_counter u_counter (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_beat_en      (beat_en),
        .i_beat_restart (beat_restart),
        .i_beat_skip    (beat_skip),
        .o_block_count  (o_block_count)
    );

    ghash_key_powers u_key (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_key_load (key_load),
        .i_key      (i_key),
        .o_h        (h),
        .o_h2       (h2)
    );

    ghash_core u_core (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_beat_en      (beat_en),
        .i_beat_restart (beat_restart),
        .i_beat_last    (beat_last),
        .i_beat_skip    (beat_skip),
        .i_data         (i_data),
        .i_h            (h),
        .i_h2           (h2),
        .o_hash         (o_hash),
        .o_hash_valid   (o_hash_valid)
    );

endmodule

// File: tests/ghash_ref.svh
`ifndef GHASH_REF_SVH
`define GHASH_REF_SVH

// bit-serial GF(2^128) product in GCM order
// bit 127 of a block is the x^0 coefficient
function automatic logic [127:0] gf_mul_serial(input logic [127:0] x, input logic [127:0] y);
    logic [127:0] z;
    logic [127:0] v;
    logic [127:0] r;
    int i;
    z = '0;
    v = y;
    // 1 + x + x^2 + x^7 in reflected form
    r = {8'he1, 120'd0};
    // walk x from its x^0 coefficient upward
    for (i = 127; i >= 0; i--) begin
        if (x[i]) begin
            z = z ^ v;
        end
        // v times x, reduce when x^127 falls off
        if (v[0]) begin
            v = (v >> 1) ^ r;
        end else begin
            v = v >> 1;
        end
    end
    return z;
endfunction

// one beat of the two-lane accumulate
// skip beat carries only block 0
function automatic logic [127:0] ghash_beat(input logic [127:0] y, input logic [127:0] x0,
                                            input logic [127:0] x1, input logic [127:0] h,
                                            input logic [127:0] h2, input logic skip);
    if (skip) begin
        return gf_mul_serial(y ^ x0, h);
    end
    return gf_mul_serial(y ^ x0, h2) ^ gf_mul_serial(x1, h);
endfunction

`endif

// File: tests/tb_ghash.sv
`timescale 1ns/1ps

module tb_ghash;

    `include "ghash_ref.svh"

    localparam int CLK_PERIOD  = 40;
    localparam int TIMEOUT     = 50;
    localparam int MAX_ENTRIES = 16;
    // two test keys
    localparam logic [127:0] KEY_A = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;
    localparam logic [127:0] KEY_B = 128'hb83b533708bf535d0aa6e52980d53b78;

    logic                           i_clock;
    logic                           i_reset;
    logic                           i_key_valid;
    logic [ghash_pkg::NB_BLOCK-1:0] i_key;
    logic                           i_valid;
    logic [ghash_pkg::NB_DATA-1:0]  i_data;
    logic                           i_sop;
    logic                           i_eop;
    logic                           i_skip;
    logic                           o_ready;
    logic [ghash_pkg::NB_BLOCK-1:0] o_hash;
    logic                           o_hash_valid;
    logic [ghash_pkg::NB_COUNT-1:0] o_block_count;
    logic                           o_proto_error;

    // stimulus table with one row per message
    logic [127:0] tab_key    [0:MAX_ENTRIES-1];
    int           tab_beats  [0:MAX_ENTRIES-1];
    logic         tab_skip   [0:MAX_ENTRIES-1];
    logic         tab_no_sop [0:MAX_ENTRIES-1];
    logic         tab_err    [0:MAX_ENTRIES-1];
    int           n_entries;

    // results in flight until the valid pulse pops them
    logic [127:0] exp_hash_q  [$];
    logic [15:0]  exp_count_q [$];
    int           exp_cycle_q [$];

    logic [31:0]  rng_state;
    logic [127:0] cur_h;
    logic [127:0] cur_h2;
    logic         key_loaded;
    int           error_count;
    int           cycle_count = 0;
    int           e;

    ghash_top u_ghash_top (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_key_valid   (i_key_valid),
        .i_key         (i_key),
        .i_valid       (i_valid),
        .i_data        (i_data),
        .i_sop         (i_sop),
        .i_eop         (i_eop),
        .i_skip        (i_skip),
        .o_ready       (o_ready),
        .o_hash        (o_hash),
        .o_hash_valid  (o_hash_valid),
        .o_block_count (o_block_count),
        .o_proto_error (o_proto_error)
    );

    initial begin
        i_clock = 1'b0;
        forever #(CLK_PERIOD/2) i_clock = ~i_clock;
    end

    // edge count for timing the valid pulse
    always @(posedge i_clock) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic stop_run();
        error_count++;
        $display("CHECKS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        assert (actual === expected) else begin
            $display("[ERROR] %s expected 0x%0h got 0x%0h", name, expected, actual);
            stop_run();
        end
    endtask

    // 32-bit LCG
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [127:0] rand_block();
        logic [127:0] blk;
        int k;
        for (k = 0; k < 4; k++) begin
            blk[32*k +: 32] = next_rand();
        end
        return blk;
    endfunction

    task automatic add_entry(input logic [127:0] key, input int beats, input logic skip,
                             input logic no_sop, input logic err);
        tab_key[n_entries]    = key;
        tab_beats[n_entries]  = beats;
        tab_skip[n_entries]   = skip;
        tab_no_sop[n_entries] = no_sop;
        tab_err[n_entries]    = err;
        n_entries++;
    endtask

    // entered at a falling edge and left at one
    task automatic wait_ready();
        int waited;
        waited = 0;
        while (!o_ready && waited < TIMEOUT) begin
            @(negedge i_clock);
            waited++;
        end
        if (!o_ready) begin
            $display("timed out waiting for o_ready to rise");
            stop_run();
        end
    endtask

    // pushed at rising edges and popped by the monitor at falling ones
    task automatic wait_drain();
        int waited;
        waited = 0;
        @(posedge i_clock);
        while (exp_hash_q.size() != 0 && waited < TIMEOUT) begin
            @(posedge i_clock);
            waited++;
        end
        if (exp_hash_q.size() != 0) begin
            $display("timed out waiting for o_hash_valid");
            stop_run();
        end
        @(negedge i_clock);
    endtask

    task automatic load_key(input logic [127:0] key);
        if (key_loaded) begin
            check_value("o_ready", 1'b1, o_ready);
        end
        i_key_valid = 1'b1;
        i_key       = key;
        @(negedge i_clock);
        i_key_valid = 1'b0;
        // stream closed while H^2 is formed
        check_value("o_ready", 1'b0, o_ready);
        @(negedge i_clock);
        check_value("o_ready", 1'b1, o_ready);
        cur_h      = key;
        cur_h2     = gf_mul_serial(key, key);
        key_loaded = 1'b1;
    endtask

    task automatic send_beat(input logic [255:0] data, input logic sop, input logic eop,
                             input logic skip, input logic push, input logic [127:0] exp_hash,
                             input logic [15:0] exp_count);
        wait_ready();
        i_valid = 1'b1;
        i_data  = data;
        i_sop   = sop;
        i_eop   = eop;
        i_skip  = skip;
        // accepted on this edge
        @(posedge i_clock);
        if (push) begin
            exp_hash_q.push_back(exp_hash);
            exp_count_q.push_back(exp_count);
            exp_cycle_q.push_back(cycle_count);
        end
        @(negedge i_clock);
        i_valid = 1'b0;
        i_sop   = 1'b0;
        i_eop   = 1'b0;
        i_skip  = 1'b0;
    endtask

    task automatic run_entry(input int idx);
        logic [127:0] y;
        logic [127:0] x0;
        logic [127:0] x1;
        logic [15:0]  count;
        logic         last;
        logic         sk;
        logic         sop;
        int           b;
        y     = '0;
        count = '0;
        for (b = 0; b < tab_beats[idx]; b++) begin
            x0    = rand_block();
            x1    = rand_block();
            last  = (b == tab_beats[idx] - 1);
            sk    = last & tab_skip[idx];
            sop   = (b == 0) & ~tab_no_sop[idx];
            y     = ghash_beat(y, x0, x1, cur_h, cur_h2, sk);
            count = count + (sk ? 16'd1 : 16'd2);
            // i_skip is held on every beat of a skip row and only counts on the last
            // dropped beats leave no result behind
            send_beat({x1, x0}, sop, last, tab_skip[idx], last & ~tab_no_sop[idx], y, count);
        end
        check_value("o_proto_error", tab_err[idx], o_proto_error);
    endtask

    // result monitor
    always @(negedge i_clock) begin
        if (!i_reset && o_hash_valid) begin
            if (exp_hash_q.size() == 0) begin
                $display("o_hash_valid pulsed with no message pending");
                stop_run();
            end else begin
                check_value("o_hash", exp_hash_q[0], o_hash);
                check_value("o_block_count", exp_count_q[0], o_block_count);
                assert (cycle_count == exp_cycle_q[0] + 1) else begin
                    $display("o_hash_valid came %0d cycles after the last beat, not 1",
                             cycle_count - exp_cycle_q[0]);
                    stop_run();
                end
                void'(exp_hash_q.pop_front());
                void'(exp_count_q.pop_front());
                void'(exp_cycle_q.pop_front());
            end
        end
    end

    initial begin
        i_reset     = 1'b1;
        i_key_valid = 1'b0;
        i_key       = '0;
        i_valid     = 1'b0;
        i_data      = '0;
        i_sop       = 1'b0;
        i_eop       = 1'b0;
        i_skip      = 1'b0;
        rng_state   = 32'h9fb0;
        cur_h       = '0;
        cur_h2      = '0;
        key_loaded  = 1'b0;
        error_count = 0;
        n_entries   = 0;
        // key, beats, skip, no sop, error expected after the row
        add_entry(KEY_A, 1, 1'b0, 1'b0, 1'b0);
        add_entry(KEY_A, 4, 1'b1, 1'b0, 1'b0);
        // these two follow with no idle cycle
        add_entry(KEY_A, 3, 1'b0, 1'b0, 1'b0);
        add_entry(KEY_A, 2, 1'b1, 1'b0, 1'b0);
        add_entry(KEY_B, 3, 1'b0, 1'b0, 1'b0);
        // orphan beat, then proper messages
        add_entry(KEY_B, 1, 1'b0, 1'b1, 1'b1);
        add_entry(KEY_B, 2, 1'b0, 1'b0, 1'b1);
        add_entry(KEY_B, 1, 1'b1, 1'b0, 1'b1);
        repeat (3) @(negedge i_clock);
        i_reset = 1'b0;
        check_value("o_ready", 1'b0, o_ready);
        check_value("o_hash_valid", 1'b0, o_hash_valid);
        check_value("o_proto_error", 1'b0, o_proto_error);
        check_value("o_hash", '0, o_hash);
        check_value("o_block_count", '0, o_block_count);
        for (e = 0; e < n_entries; e++) begin
            // new key only between messages
            if (!key_loaded || tab_key[e] !== cur_h) begin
                wait_drain();
                load_key(tab_key[e]);
            end
            run_entry(e);
        end
        wait_drain();
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+tests
src/ghash_pkg.sv
src/gf128_mult.sv
src/ghash_key_powers.sv
src/ghash_core.sv
src/ghash_ctrl.sv
src/ghash_block_counter.sv
src/ghash_top.sv
tests/tb_ghash.sv

// File: Bender.yml
package:
  name: ghash

sources:
  - src/ghash_pkg.sv
  - src/gf128_mult.sv
  - src/ghash_key_powers.sv
  - src/ghash_core.sv
  - src/ghash_ctrl.sv
  - src/ghash_block_counter.sv
  - src/ghash_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_ghash.sv
